// ==== Makefile ====
SIM = obj_dir/Vtb_snow64_decode_unit

$(SIM): sources.f $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_snow64_decode_unit -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== rtl/snow64_apb_regs.sv ====
`timescale 1ns/1ps
`include "snow64_decoder_params.svh"

module snow64_apb_regs (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`SNOW64_APB_ADDR_WIDTH-1:0] paddr,
	input logic [`SNOW64_APB_DATA_WIDTH-1:0] pwdata,
	output logic [`SNOW64_APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	snow64_stream_if.source instr_out,
	snow64_stream_if.sink result_in,
	input logic instr_full,
	input logic [`SNOW64_COUNT_WIDTH-1:0] result_count
);

	logic setup_phase;
	logic access_phase;
	logic [`SNOW64_APB_DATA_WIDTH-1:0] next_rdata;
	logic next_err;
	snow64_decoder_pkg::decoded_instr_t head;

	assign setup_phase = psel && !penable;
	assign access_phase = psel && penable;
	assign pready = 1'b1;
	assign head = result_in.data;

	// response is worked out during setup so it is ready for the access phase
	always_comb
	begin
		next_rdata = '0;
		next_err = 1'b0;
		if (pwrite)
		begin
			next_err = (paddr == `SNOW64_REG_INSTR) && instr_full;
		end
		else
		begin
			case (paddr)
			`SNOW64_REG_DEC_FIELDS:
			begin
				if (result_in.valid)
					next_rdata = {head.group, head.op_type, head.oper, head.ra_index,
						head.rb_index, head.rc_index, 11'd0, head.nop};
				else
					next_err = 1'b1;
			end
			`SNOW64_REG_DEC_IMM:
			begin
				if (result_in.valid)
					next_rdata = head.signext_imm;
				else
					next_err = 1'b1;
			end
			`SNOW64_REG_STATUS:
			begin
				next_rdata = {{(`SNOW64_APB_DATA_WIDTH - 8){1'b0}}, 4'(result_count),
					2'b00, (result_count == '0), instr_full};
			end
			default:
			begin
				next_rdata = '0;
			end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prdata <= '0;
			pslverr <= 1'b0;
		end
		else if (setup_phase)
		begin
			prdata <= next_rdata;
			pslverr <= next_err;
		end
		else if (!psel)
		begin
			prdata <= '0;
			pslverr <= 1'b0;
		end
	end

	// push on the access phase, unless setup flagged the queue as full
	assign instr_out.valid = access_phase && pwrite && (paddr == `SNOW64_REG_INSTR) && !pslverr;
	assign instr_out.data = pwdata;

	// reading the immediate retires the head result
	assign result_in.ready = access_phase && !pwrite && (paddr == `SNOW64_REG_DEC_IMM)
		&& !pslverr;

	penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel);

	// setup must lead into access on the same register
	setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
		setup_phase |=> access_phase && $stable(paddr) && $stable(pwrite));

endmodule

// ==== rtl/snow64_decode_unit.sv ====
`timescale 1ns/1ps
`include "snow64_decoder_params.svh"

module snow64_decode_unit (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`SNOW64_APB_ADDR_WIDTH-1:0] paddr,
	input logic [`SNOW64_APB_DATA_WIDTH-1:0] pwdata,
	output logic [`SNOW64_APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	localparam int count_width = `SNOW64_COUNT_WIDTH;
	localparam logic [count_width-1:0] full_count = count_width'(`SNOW64_FIFO_DEPTH);

	logic [count_width-1:0] instr_count;
	logic [count_width-1:0] result_count;
	logic instr_full;

	// apb -> instr queue -> decoder -> result queue -> apb
	snow64_stream_if #(.payload_t(snow64_decoder_pkg::instr_word_t)) instr_stream ();
	snow64_stream_if #(.payload_t(snow64_decoder_pkg::instr_word_t)) decode_in ();
	snow64_stream_if #(.payload_t(snow64_decoder_pkg::decoded_instr_t)) decode_out ();
	snow64_stream_if #(.payload_t(snow64_decoder_pkg::decoded_instr_t)) result_stream ();

	assign instr_full = (instr_count == full_count);

	snow64_apb_regs u_apb_regs (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.instr_out(instr_stream.source),
		.result_in(result_stream.sink),
		.instr_full(instr_full),
		.result_count(result_count)
	);

	snow64_sync_fifo #(.payload_t(snow64_decoder_pkg::instr_word_t)) instr_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in(instr_stream.sink),
		.out(decode_in.source),
		.count(instr_count)
	);

	snow64_instr_decoder u_decoder (
		.in(decode_in.sink),
		.out(decode_out.source)
	);

	snow64_sync_fifo #(.payload_t(snow64_decoder_pkg::decoded_instr_t)) result_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in(decode_out.sink),
		.out(result_stream.source),
		.count(result_count)
	);

endmodule

// ==== rtl/snow64_decoder_params.svh ====
`ifndef SNOW64_DECODER_PARAMS_SVH
`define SNOW64_DECODER_PARAMS_SVH

// raw instruction word
`define SNOW64_INSTR_WIDTH 32

// width of the sign-extended immediate
`define SNOW64_ADDR_WIDTH 32

// entries per queue
`define SNOW64_FIFO_DEPTH 4

// occupancy counter, wide enough to hold a full queue
`define SNOW64_COUNT_WIDTH ($clog2(`SNOW64_FIFO_DEPTH + 1))

// apb bus widths
`define SNOW64_APB_ADDR_WIDTH 8
`define SNOW64_APB_DATA_WIDTH 32

// apb register offsets
`define SNOW64_REG_INSTR 8'h00
`define SNOW64_REG_DEC_FIELDS 8'h04
`define SNOW64_REG_DEC_IMM 8'h08
`define SNOW64_REG_STATUS 8'h0c

// replicate the top bit of val up to out_w bits
`define SNOW64_SIGN_EXTEND(out_w, in_w, val) {{((out_w) - (in_w)){val[(in_w) - 1]}}, val}

`endif

// ==== rtl/snow64_decoder_pkg.sv ====
`include "snow64_decoder_params.svh"

package snow64_decoder_pkg;

	typedef logic [`SNOW64_INSTR_WIDTH-1:0] instr_word_t;

	// layout shared by groups 0, 2 and 3
	typedef struct packed {
		logic [2:0] group;
		logic op_type;
		logic [3:0] oper;
		logic [3:0] ra_index;
		logic [3:0] rb_index;
		logic [3:0] rc_index;
		logic [11:0] simm12;
	} instr_group_t;

	// branches and jumps, one register and a wide offset
	typedef struct packed {
		logic [2:0] group;
		logic op_type;
		logic [3:0] oper;
		logic [3:0] ra_index;
		logic [19:0] simm20;
	} iog1_instr_t;

	// port i/o, two registers and a 16-bit immediate
	typedef struct packed {
		logic [2:0] group;
		logic op_type;
		logic [3:0] oper;
		logic [3:0] ra_index;
		logic [3:0] rb_index;
		logic [15:0] simm16;
	} iog4_instr_t;

	// group 0 alu operations
	typedef enum logic [3:0] {
		iog0_add = 4'd0,
		iog0_sub = 4'd1,
		iog0_sltu = 4'd2,
		iog0_slts = 4'd3,
		iog0_mul = 4'd4,
		iog0_div = 4'd5,
		iog0_and = 4'd6,
		iog0_orr = 4'd7,
		iog0_xor = 4'd8,
		iog0_shl = 4'd9,
		iog0_shr = 4'd10,
		iog0_inv = 4'd11,
		iog0_not = 4'd12,
		iog0_bad0 = 4'd13,
		iog0_bad1 = 4'd14,
		iog0_bad2 = 4'd15
	} iog0_oper_t;

	// group 1 control flow, everything from bad0 up is unused
	typedef enum logic [3:0] {
		iog1_bne = 4'd0,
		iog1_beq = 4'd1,
		iog1_bltu = 4'd2,
		iog1_blts = 4'd3,
		iog1_bgeu = 4'd4,
		iog1_bges = 4'd5,
		iog1_jmp = 4'd6,
		iog1_jmpr = 4'd7,
		iog1_jal = 4'd8,
		iog1_jalr = 4'd9,
		iog1_call = 4'd10,
		iog1_ret = 4'd11,
		iog1_bad0 = 4'd12
	} iog1_oper_t;

	// group 2 loads
	typedef enum logic [3:0] {
		iog2_ldu8 = 4'd0,
		iog2_lds8 = 4'd1,
		iog2_ldu16 = 4'd2,
		iog2_lds16 = 4'd3,
		iog2_ldu32 = 4'd4,
		iog2_lds32 = 4'd5,
		iog2_ldu64 = 4'd6,
		iog2_lds64 = 4'd7,
		iog2_ldf16 = 4'd8
	} iog2_oper_t;

	// group 3 stores
	typedef enum logic [3:0] {
		iog3_st8 = 4'd0,
		iog3_st16 = 4'd2,
		iog3_st32 = 4'd4,
		iog3_st64 = 4'd6,
		iog3_stf16 = 4'd8
	} iog3_oper_t;

	// group 4 port i/o
	typedef enum logic [3:0] {
		iog4_in = 4'd0,
		iog4_out = 4'd8
	} iog4_oper_t;

	typedef struct packed {
		logic [2:0] group;
		logic op_type;
		logic [3:0] oper;
		logic [3:0] ra_index;
		logic [3:0] rb_index;
		logic [3:0] rc_index;
		logic nop;
		logic [`SNOW64_ADDR_WIDTH-1:0] signext_imm;
	} decoded_instr_t;

endpackage

// ==== rtl/snow64_instr_decoder.sv ====
`timescale 1ns/1ps
`include "snow64_decoder_params.svh"

module snow64_instr_decoder (
	snow64_stream_if.sink in,
	snow64_stream_if.source out
);

	snow64_decoder_pkg::instr_group_t iog_instr;
	snow64_decoder_pkg::iog1_instr_t iog1_instr;
	snow64_decoder_pkg::iog4_instr_t iog4_instr;
	snow64_decoder_pkg::decoded_instr_t dec;

	// same word seen through each group layout
	assign iog_instr = in.data;
	assign iog1_instr = in.data;
	assign iog4_instr = in.data;

	// no storage here, handshake goes straight through
	assign out.valid = in.valid;
	assign in.ready = out.ready;
	assign out.data = dec;

	always_comb
	begin
		dec.group = iog_instr.group;
		dec.op_type = iog_instr.op_type;
		dec.ra_index = iog_instr.ra_index;
		dec.rb_index = iog_instr.rb_index;
		dec.rc_index = iog_instr.rc_index;

		case (iog_instr.group)
		3'd0:
		begin
			dec.oper = iog_instr.oper;
			dec.nop = (iog_instr.oper == snow64_decoder_pkg::iog0_bad0)
				|| (iog_instr.oper == snow64_decoder_pkg::iog0_bad1)
				|| (iog_instr.oper == snow64_decoder_pkg::iog0_bad2);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(`SNOW64_ADDR_WIDTH,
				$bits(iog_instr.simm12), iog_instr.simm12);
		end

		3'd1:
		begin
			dec.oper = iog1_instr.oper;
			dec.nop = (iog1_instr.oper >= snow64_decoder_pkg::iog1_bad0);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(`SNOW64_ADDR_WIDTH,
				$bits(iog1_instr.simm20), iog1_instr.simm20);
		end

		3'd2:
		begin
			dec.oper = iog_instr.oper;
			// upper half is unused apart from ldf16
			dec.nop = iog_instr.oper[3]
				&& (iog_instr.oper != snow64_decoder_pkg::iog2_ldf16);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(`SNOW64_ADDR_WIDTH,
				$bits(iog_instr.simm12), iog_instr.simm12);
		end

		3'd3:
		begin
			dec.oper = iog_instr.oper;
			dec.nop = iog_instr.oper[3]
				&& (iog_instr.oper != snow64_decoder_pkg::iog3_stf16);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(`SNOW64_ADDR_WIDTH,
				$bits(iog_instr.simm12), iog_instr.simm12);
		end

		3'd4:
		begin
			dec.oper = iog4_instr.oper;
			dec.nop = iog4_instr.oper[3]
				&& (iog4_instr.oper != snow64_decoder_pkg::iog4_out);
			dec.signext_imm = `SNOW64_SIGN_EXTEND(`SNOW64_ADDR_WIDTH,
				$bits(iog4_instr.simm16), iog4_instr.simm16);
		end

		// groups 5 to 7 are not defined yet
		default:
		begin
			dec.oper = '0;
			dec.nop = 1'b1;
			dec.signext_imm = '0;
		end
		endcase
	end

endmodule

// ==== rtl/snow64_stream_if.sv ====
`timescale 1ns/1ps

interface snow64_stream_if #(
	parameter type payload_t = snow64_decoder_pkg::instr_word_t
) ();

	logic valid;
	logic ready;
	payload_t data;

	// data is held from valid until the beat is taken
	modport source (
		output valid,
		output data,
		input ready
	);

	modport sink (
		input valid,
		input data,
		output ready
	);

endinterface

// ==== rtl/snow64_sync_fifo.sv ====
`timescale 1ns/1ps
`include "snow64_decoder_params.svh"

module snow64_sync_fifo #(
	parameter type payload_t = snow64_decoder_pkg::instr_word_t
) (
	input logic clk,
	input logic rst_n,
	snow64_stream_if.sink in,
	snow64_stream_if.source out,
	output logic [`SNOW64_COUNT_WIDTH-1:0] count
);

	localparam int depth = `SNOW64_FIFO_DEPTH;
	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_width = `SNOW64_COUNT_WIDTH;
	localparam logic [count_width-1:0] full_count = count_width'(depth);
	localparam logic [ptr_width-1:0] last_ptr = ptr_width'(depth - 1);

	payload_t mem [depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic push;
	logic pop;

	assign in.ready = (count != full_count);
	assign push = in.valid && in.ready;

	// head is visible the cycle after it was written
	assign out.valid = (count != '0);
	assign out.data = mem[rd_ptr];
	assign pop = out.valid && out.ready;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in.data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// occupancy stays within depth and agrees with the pointer distance
	count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= full_count && (int'(rd_ptr) + int'(count)) % depth == int'(wr_ptr));

	// a stalled upstream beat must hold until this queue takes it
	in_stable: assert property (@(posedge clk) disable iff (!rst_n)
		in.valid && !in.ready |=> in.valid && $stable(in.data));

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/snow64_decoder_pkg.sv
rtl/snow64_stream_if.sv
rtl/snow64_sync_fifo.sv
rtl/snow64_instr_decoder.sv
rtl/snow64_apb_regs.sv
rtl/snow64_decode_unit.sv
testbench/snow64_decode_checker.sv
testbench/tb_snow64_decode_unit.sv

// ==== testbench/snow64_decode_checker.sv ====
`timescale 1ns/1ps
`include "snow64_decoder_params.svh"

module snow64_decode_checker (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`SNOW64_APB_ADDR_WIDTH-1:0] paddr,
	input logic [`SNOW64_APB_DATA_WIDTH-1:0] pwdata,
	input logic [`SNOW64_APB_DATA_WIDTH-1:0] prdata,
	input logic pready,
	input logic pslverr,
	output int errors
);

	localparam int max_in_flight = 2 * `SNOW64_FIFO_DEPTH;

	string test_name;
	// accepted words not yet popped with the oldest at the front
	logic [31:0] model_q[$];

	function automatic logic [31:0] expected_fields(input logic [31:0] w);
		logic [3:0] oper;
		logic nop;
		oper = w[27:24];
		case (w[31:29])
		3'd0: nop = (oper >= 4'd13);
		3'd1: nop = (oper >= 4'd12);
		3'd2, 3'd3, 3'd4: nop = (oper >= 4'd9);
		default:
		begin
			nop = 1'b1;
			oper = 4'd0;
		end
		endcase
		return {w[31:28], oper, w[23:12], 11'd0, nop};
	endfunction

	function automatic logic [31:0] expected_imm(input logic [31:0] w);
		case (w[31:29])
		3'd0, 3'd2, 3'd3: return {{20{w[11]}}, w[11:0]};
		3'd1: return {{12{w[19]}}, w[19:0]};
		3'd4: return {{16{w[15]}}, w[15:0]};
		default: return 32'd0;
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	initial
	begin
		errors = 0;
		test_name = "reset";
	end

	// this slave never inserts wait states
	always @(posedge clk)
	begin
		if (rst_n && psel && penable)
			compare("pready", 32'd1, {31'd0, pready});
	end

	// access completes on the edge with penable and pready high
	always @(posedge clk)
	begin
		if (rst_n && psel && penable && pready)
		begin
			if (pwrite && paddr == `SNOW64_REG_INSTR)
			begin
				compare("pslverr", {31'd0, model_q.size() >= max_in_flight}, {31'd0, pslverr});
				if (!pslverr)
					model_q.push_back(pwdata);
			end
			else if (!pwrite && (paddr == `SNOW64_REG_DEC_FIELDS || paddr == `SNOW64_REG_DEC_IMM))
			begin
				compare("pslverr", {31'd0, model_q.size() == 0}, {31'd0, pslverr});
				if (model_q.size() == 0)
					compare("empty prdata", 32'd0, prdata);
				else if (paddr == `SNOW64_REG_DEC_FIELDS)
					compare("dec_fields", expected_fields(model_q[0]), prdata);
				else
				begin
					compare("dec_imm", expected_imm(model_q[0]), prdata);
					void'(model_q.pop_front());
				end
			end
			else if (!pwrite && paddr == `SNOW64_REG_STATUS)
			begin
				compare("status pslverr", 32'd0, {31'd0, pslverr});
				// status is only fixed once nothing is moving between the queues
				if (model_q.size() == 0)
					compare("status", 32'h0000_0002, prdata);
				else if (model_q.size() >= max_in_flight)
					compare("status", {24'd0, 4'(`SNOW64_FIFO_DEPTH), 4'b0001}, prdata);
			end
		end
	end

endmodule

// ==== testbench/tb_snow64_decode_unit.sv ====
`timescale 1ns/1ps
`include "snow64_decoder_params.svh"

module tb_snow64_decode_unit;

	typedef enum {
		act_decode,
		act_write,
		act_peek,
		act_check,
		act_status,
		act_empty,
		act_fill,
		act_random
	} action_t;

	typedef struct {
		string name;
		logic [31:0] word;
		action_t act;
	} row_t;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`SNOW64_APB_ADDR_WIDTH-1:0] paddr;
	logic [`SNOW64_APB_DATA_WIDTH-1:0] pwdata;
	logic [`SNOW64_APB_DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;
	int check_errors;
	int timeouts;
	logic [31:0] lfsr;
	row_t rows[$];

	snow64_decode_unit DUT (.*);

	snow64_decode_checker u_checker (.*, .errors(check_errors));

	always #4 clk = ~clk;

	function automatic void add_row(input string name, input logic [31:0] word,
		input action_t act);
		rows.push_back('{name, word, act});
	endfunction

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] next_random_word();
		logic [31:0] word;
		word = '0;
		for (int i = 0; i < 32; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			word = {word[30:0], lfsr[0]};
		end
		return word;
	endfunction

	// setup and access on falling edges, idle cycle after
	task automatic apb_access(input logic write, input logic [`SNOW64_APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		while (!pready && waited < 16)
		begin
			@(posedge clk);
			waited++;
		end
		if (!pready)
		begin
			$display("timeout: pready stayed low on access to offset %h", addr);
			timeouts++;
		end
		rdata = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_word(input logic [31:0] word);
		logic [31:0] rdata;
		apb_access(1'b1, `SNOW64_REG_INSTR, word, rdata);
	endtask

	task automatic read_reg(input logic [`SNOW64_APB_ADDR_WIDTH-1:0] addr);
		logic [31:0] rdata;
		apb_access(1'b0, addr, 32'd0, rdata);
	endtask

	// poll status until the result queue holds something
	task automatic wait_for_result();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = 32'h2;
		while (status[1] && polls < 20 && timeouts == 0)
		begin
			apb_access(1'b0, `SNOW64_REG_STATUS, 32'd0, status);
			polls++;
		end
		if (status[1] && timeouts == 0)
		begin
			$display("timeout: no decoded result appeared after %0d status polls", polls);
			timeouts++;
		end
	endtask

	task automatic read_result();
		wait_for_result();
		if (timeouts == 0)
		begin
			read_reg(`SNOW64_REG_DEC_FIELDS);
			read_reg(`SNOW64_REG_DEC_IMM);
		end
	endtask

	task automatic run_row(input row_t row);
		u_checker.test_name = row.name;
		case (row.act)
		act_decode:
		begin
			write_word(row.word);
			read_result();
		end
		act_write: write_word(row.word);
		act_peek:
		begin
			wait_for_result();
			read_reg(`SNOW64_REG_DEC_FIELDS);
		end
		act_check: read_result();
		act_status: read_reg(`SNOW64_REG_STATUS);
		act_empty:
		begin
			read_reg(`SNOW64_REG_DEC_FIELDS);
			read_reg(`SNOW64_REG_DEC_IMM);
		end
		act_fill:
		begin
			// one word more than both queues hold, the last is dropped
			for (int i = 0; i <= 2 * `SNOW64_FIFO_DEPTH; i++)
				write_word(row.word + 32'(i));
			read_reg(`SNOW64_REG_STATUS);
			for (int i = 0; i < 2 * `SNOW64_FIFO_DEPTH && timeouts == 0; i++)
				read_result();
		end
		act_random:
		begin
			// four batches of four keep the queues from overflowing
			for (int b = 0; b < 4; b++)
			begin
				for (int i = 0; i < 4; i++)
					write_word(next_random_word());
				for (int i = 0; i < 4; i++)
					read_result();
			end
		end
		endcase
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		timeouts = 0;
		lfsr = 32'h6eaf_4384;
		add_row("status_after_reset", 32'd0, act_status);
		add_row("read_while_empty", 32'd0, act_empty);
		add_row("g0_oper12_neg_imm", 32'h1c56_78f0, act_decode);
		add_row("g0_oper13_nop", 32'h0d00_0123, act_decode);
		add_row("g1_oper11_pos_imm", 32'h2b31_2345, act_decode);
		add_row("g1_oper12_nop_neg", 32'h3c4f_ffff, act_decode);
		add_row("g2_ldf16_neg_imm", 32'h4812_3800, act_decode);
		add_row("g2_oper9_nop", 32'h4912_307f, act_decode);
		add_row("g3_stf16", 32'h6845_6001, act_decode);
		add_row("g3_oper9_nop_neg", 32'h7945_6fff, act_decode);
		add_row("g4_out_neg_imm", 32'h8834_8000, act_decode);
		add_row("g4_oper9_nop_pos", 32'h9934_7fff, act_decode);
		add_row("g5_undefined", 32'ha5ff_ffff, act_decode);
		add_row("g6_undefined", 32'hc123_4567, act_decode);
		add_row("g7_undefined", 32'hef00_0abc, act_decode);
		add_row("order_write_a", 32'h0123_4001, act_write);
		add_row("order_write_b", 32'h2a12_fff0, act_write);
		add_row("order_write_c", 32'h8534_8765, act_write);
		add_row("order_peek", 32'd0, act_peek);
		add_row("order_peek_again", 32'd0, act_peek);
		add_row("order_read_a", 32'd0, act_check);
		add_row("order_read_b", 32'd0, act_check);
		add_row("order_read_c", 32'd0, act_check);
		add_row("back_pressure", 32'h4321_0800, act_fill);
		add_row("status_drained", 32'd0, act_status);
		add_row("random_words", 32'd0, act_random);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (rows[i])
		begin
			if (timeouts == 0)
				run_row(rows[i]);
		end
		$display("done: %0d mismatches, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
